// ==== source/header_capture_pkg.sv ====
package header_capture_pkg;

	// One 16-bit stream beat, byte 0 in the low bits and first on the wire
	typedef logic [15:0] beat_data_t;

	// Byte enables of one beat
	typedef logic [1:0] beat_keep_t;

	// MAC address in network order, first wire byte most significant
	typedef logic [47:0] mac_address_t;

	// EtherType in network order
	typedef logic [15:0] ether_type_t;

	// One's-complement checksum
	typedef logic [15:0] checksum_t;

	// Captured Ethernet header, wire byte k at bits 8k+7..8k
	typedef logic [111:0] header_bytes_t;

	// 14 header bytes over 2-byte beats
	localparam int HEADER_BEATS = 7;

	localparam ether_type_t ETHER_TYPE_IPV4 = 16'h0800;

	// Splitter FSM
	typedef enum logic [1:0] {
		HEADER,
		PAYLOAD,
		DISCARD
	} splitter_state_t;

endpackage

// ==== source/stream_header_splitter.sv ====
module stream_header_splitter
	import header_capture_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic in_valid,
	input beat_data_t in_data,
	input beat_keep_t in_keep,
	input logic in_last,
	output logic in_ready,
	output logic out_valid,
	output beat_data_t out_data,
	output beat_keep_t out_keep,
	output logic out_last,
	input logic out_ready,
	output logic header_capture,
	output header_bytes_t header_bytes
);

	localparam int COUNT_WIDTH = $clog2(HEADER_BEATS);

	splitter_state_t state;
	logic [COUNT_WIDTH-1:0] header_count;
	logic in_taken;
	logic payload_taken;
	logic out_free;
	logic header_done;

	// Output register is empty or empties at this edge
	assign out_free = !out_valid || out_ready;

	assign in_taken = in_valid && in_ready;
	assign payload_taken = in_taken && (state == PAYLOAD);
	assign header_done = (header_count == COUNT_WIDTH'(HEADER_BEATS - 1));

	// The final header beat waits until the previous frame has left the
	// output register, so its end cannot clear the new header
	always_comb begin
		case (state)
			HEADER: begin
				in_ready = !header_done || out_free;
			end
			PAYLOAD: begin
				in_ready = out_free;
			end
			default: begin
				in_ready = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= HEADER;
			header_count <= '0;
			header_capture <= 1'b0;
		end else begin
			header_capture <= 1'b0;
			case (state)
				HEADER: begin
					if (in_taken) begin
						if (in_last) begin
							// Frame ended inside its header
							header_count <= '0;
							if (out_valid) begin
								state <= DISCARD;
							end
						end else if (header_done) begin
							header_count <= '0;
							header_capture <= 1'b1;
							state <= PAYLOAD;
						end else begin
							header_count <= header_count + 1'b1;
						end
					end
				end
				PAYLOAD: begin
					if (in_taken && in_last) begin
						state <= HEADER;
					end
				end
				DISCARD: begin
					if (out_free) begin
						state <= HEADER;
					end
				end
				default: begin
					state <= HEADER;
				end
			endcase
		end
	end

	// Header beats enter at the top, so beat 0 ends up in the low bits
	always_ff @(posedge clock) begin
		if (in_taken && (state == HEADER)) begin
			header_bytes <= {in_data, header_bytes[$bits(header_bytes_t)-1:$bits(beat_data_t)]};
		end
	end

	// One-entry output stage
	always_ff @(posedge clock) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (payload_taken) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (payload_taken) begin
			out_data <= in_data;
			out_keep <= in_keep;
			out_last <= in_last;
		end
	end

endmodule

// ==== source/ethernet_header_decoder.sv ====
module ethernet_header_decoder
	import header_capture_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic header_capture,
	input header_bytes_t header_bytes,
	input logic frame_done,
	output logic header_valid,
	output mac_address_t destination_mac,
	output mac_address_t source_mac,
	output ether_type_t ether_type,
	output logic is_ipv4
);

	localparam int MAC_BYTES = 6;
	localparam int TYPE_OFFSET = 2 * MAC_BYTES;

	mac_address_t next_destination;
	mac_address_t next_source;
	ether_type_t next_ether_type;

	// Earlier wire byte goes to the more significant position
	always_comb begin
		for (int k = 0; k < MAC_BYTES; k++) begin
			next_destination[8*(MAC_BYTES-1-k) +: 8] = header_bytes[8*k +: 8];
			next_source[8*(MAC_BYTES-1-k) +: 8] = header_bytes[8*(k+MAC_BYTES) +: 8];
		end
		next_ether_type = {header_bytes[8*TYPE_OFFSET +: 8], header_bytes[8*(TYPE_OFFSET+1) +: 8]};
	end

	// A new capture wins over the end of the previous frame
	always_ff @(posedge clock) begin
		if (reset) begin
			header_valid <= 1'b0;
		end else if (header_capture) begin
			header_valid <= 1'b1;
		end else if (frame_done) begin
			header_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (header_capture) begin
			destination_mac <= next_destination;
			source_mac <= next_source;
			ether_type <= next_ether_type;
			is_ipv4 <= (next_ether_type == ETHER_TYPE_IPV4);
		end
	end

endmodule

// ==== source/payload_checksum.sv ====
module payload_checksum
	import header_capture_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic beat_taken,
	input beat_data_t beat_data,
	input beat_keep_t beat_keep,
	input logic beat_last,
	output logic checksum_valid,
	output checksum_t checksum
);

	logic [15:0] word;
	logic [31:0] accumulator;
	logic [31:0] next_sum;
	logic [16:0] fold_once;
	logic [15:0] folded;

	// Byte 0 is the high byte of the word, masked bytes count as zero
	assign word = {
		beat_keep[0] ? beat_data[7:0] : 8'h00,
		beat_keep[1] ? beat_data[15:8] : 8'h00
	};

	// Carries from the previous cycle fold back in with the new word
	assign next_sum = {16'h0000, accumulator[15:0]}
		+ {16'h0000, accumulator[31:16]}
		+ {16'h0000, word};

	// next_sum stays below 2^18, two folds bring it into 16 bits
	assign fold_once = {1'b0, next_sum[15:0]} + {1'b0, next_sum[31:16]};
	assign folded = fold_once[15:0] + {15'h0000, fold_once[16]};

	always_ff @(posedge clock) begin
		if (reset) begin
			accumulator <= '0;
			checksum_valid <= 1'b0;
		end else begin
			checksum_valid <= beat_taken && beat_last;
			if (beat_taken) begin
				if (beat_last) begin
					accumulator <= '0;
				end else begin
					accumulator <= next_sum;
				end
			end
		end
	end

	// All-ones sum is reported as is
	always_ff @(posedge clock) begin
		if (beat_taken && beat_last) begin
			checksum <= (folded == 16'hFFFF) ? folded : ~folded;
		end
	end

endmodule

// ==== source/header_capture_top.sv ====
module header_capture_top
	import header_capture_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic in_valid,
	input beat_data_t in_data,
	input beat_keep_t in_keep,
	input logic in_last,
	output logic in_ready,
	output logic out_valid,
	output beat_data_t out_data,
	output beat_keep_t out_keep,
	output logic out_last,
	input logic out_ready,
	output logic header_valid,
	output mac_address_t destination_mac,
	output mac_address_t source_mac,
	output ether_type_t ether_type,
	output logic is_ipv4,
	output logic checksum_valid,
	output checksum_t checksum
);

	logic header_capture;
	header_bytes_t header_bytes;
	logic out_taken;
	logic frame_done;

	assign out_taken = out_valid && out_ready;
	assign frame_done = out_taken && out_last;

	stream_header_splitter stream_header_splitter_inst (
		.clock(clock),
		.reset(reset),
		.in_valid(in_valid),
		.in_data(in_data),
		.in_keep(in_keep),
		.in_last(in_last),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_keep(out_keep),
		.out_last(out_last),
		.out_ready(out_ready),
		.header_capture(header_capture),
		.header_bytes(header_bytes)
	);

	ethernet_header_decoder ethernet_header_decoder_inst (
		.clock(clock),
		.reset(reset),
		.header_capture(header_capture),
		.header_bytes(header_bytes),
		.frame_done(frame_done),
		.header_valid(header_valid),
		.destination_mac(destination_mac),
		.source_mac(source_mac),
		.ether_type(ether_type),
		.is_ipv4(is_ipv4)
	);

	payload_checksum payload_checksum_inst (
		.clock(clock),
		.reset(reset),
		.beat_taken(out_taken),
		.beat_data(out_data),
		.beat_keep(out_keep),
		.beat_last(out_last),
		.checksum_valid(checksum_valid),
		.checksum(checksum)
	);

endmodule

// ==== verification/header_capture_properties.sv ====
module header_capture_properties
	import header_capture_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic out_valid,
	input beat_data_t out_data,
	input beat_keep_t out_keep,
	input logic out_last,
	input logic out_ready,
	input logic header_valid,
	input logic checksum_valid
);

	// A stalled beat holds until the sink takes it
	output_held_while_stalled: assert property (
		@(posedge clock) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_keep)
			&& $stable(out_last)
	) else $error("Output beat changed while out_ready was low");

	reset_clears_outputs: assert property (
		@(posedge clock) reset |=> !out_valid && !header_valid && !checksum_valid
	) else $error("Valid outputs were not low in the cycle after reset");

	checksum_single_pulse: assert property (
		@(posedge clock) disable iff (reset)
		checksum_valid |=> !checksum_valid
	) else $error("checksum_valid stayed high for two cycles");

endmodule

// ==== include/header_capture_tb_tasks.svh ====
`ifndef HEADER_CAPTURE_TB_TASKS_SVH
`define HEADER_CAPTURE_TB_TASKS_SVH

// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
	return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
endfunction

// One LFSR step per bit drawn, up to 32 bits
function automatic logic [31:0] lfsr_draw(ref logic [15:0] state, input int bit_count);
	logic [31:0] value;
	value = '0;
	for (int i = 0; i < bit_count; i++) begin
		state = lfsr_step(state);
		value = {value[30:0], state[0]};
	end
	return value;
endfunction

// Earlier byte is the high byte, odd tail padded with zero
function automatic logic [15:0] reference_checksum(input byte unsigned payload[$]);
	logic [31:0] sum;
	sum = '0;
	for (int i = 0; i < payload.size(); i += 2) begin
		sum += {payload[i], (i + 1 < payload.size()) ? payload[i+1] : 8'h00};
	end
	while (sum[31:16] != 0) begin
		sum = sum[31:16] + sum[15:0];
	end
	return (sum[15:0] == 16'hFFFF) ? sum[15:0] : ~sum[15:0];
endfunction

// Sends header and payload bytes as one frame, called right after a rising edge
task automatic send_frame(input byte unsigned frame_bytes[$]);
	int beat_count;
	int n;
	beat_count = (frame_bytes.size() + 1) / 2;
	for (int b = 0; b < beat_count; b++) begin
		n = 2 * b;
		in_valid <= 1'b1;
		in_data <= {(n + 1 < frame_bytes.size()) ? frame_bytes[n+1] : 8'h00, frame_bytes[n]};
		in_keep <= (n + 1 < frame_bytes.size()) ? 2'b11 : 2'b01;
		in_last <= (b == beat_count - 1);
		@(posedge clock);
		while (!in_ready) begin
			@(posedge clock);
		end
	end
	in_valid <= 1'b0;
	in_last <= 1'b0;
endtask

`endif

// ==== verification/header_capture_tb.sv ====
module header_capture_tb
	import header_capture_pkg::*;
();

	localparam int CLOCK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	localparam logic [15:0] LFSR_SEED = 16'd15766;
	localparam int IPV4_LENGTH = 40;
	localparam int OTHER_LENGTH = 24;
	localparam int ODD_LENGTH = 33;
	localparam int STALL_LENGTH_0 = 30;
	localparam int STALL_LENGTH_1 = 17;
	localparam int STALL_LENGTH_2 = 48;
	localparam int STALL_LENGTH_3 = 9;
	localparam int TRUNCATED_BYTES = 9;
	localparam int RECOVERY_LENGTH = 20;
	// Eight complete frames plus the one cut short in its header
	localparam int TOTAL_BEATS = 8 * HEADER_BEATS
		+ (IPV4_LENGTH + 1) / 2 + (OTHER_LENGTH + 1) / 2 + (ODD_LENGTH + 1) / 2
		+ (STALL_LENGTH_0 + 1) / 2 + (STALL_LENGTH_1 + 1) / 2
		+ (STALL_LENGTH_2 + 1) / 2 + (STALL_LENGTH_3 + 1) / 2
		+ (TRUNCATED_BYTES + 1) / 2 + (RECOVERY_LENGTH + 1) / 2;
	localparam int TIMEOUT_CYCLES = 2 * TOTAL_BEATS + 200;

	logic clock;
	logic reset;
	logic in_valid;
	beat_data_t in_data;
	beat_keep_t in_keep;
	logic in_last;
	logic in_ready;
	logic out_valid;
	beat_data_t out_data;
	beat_keep_t out_keep;
	logic out_last;
	logic out_ready;
	logic header_valid;
	mac_address_t destination_mac;
	mac_address_t source_mac;
	ether_type_t ether_type;
	logic is_ipv4;
	logic checksum_valid;
	checksum_t checksum;

	logic [15:0] payload_lfsr;
	logic [15:0] ready_lfsr;
	logic stall_enable;
	logic header_forbidden;
	logic checksum_due;
	logic held_valid;
	logic [18:0] held_beat;
	// Beat is {last, keep, data}
	logic [18:0] expected_beats[$];
	// Header is {destination, source, type, ipv4}
	logic [112:0] expected_headers[$];
	checksum_t expected_checksums[$];
	int cycle_count;
	int check_count;
	int error_count;
	int errors_before;
	int frame_count;

	`include "header_capture_tb_tasks.svh"

	header_capture_top header_capture_top_inst (
		.clock(clock),
		.reset(reset),
		.in_valid(in_valid),
		.in_data(in_data),
		.in_keep(in_keep),
		.in_last(in_last),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_keep(out_keep),
		.out_last(out_last),
		.out_ready(out_ready),
		.header_valid(header_valid),
		.destination_mac(destination_mac),
		.source_mac(source_mac),
		.ether_type(ether_type),
		.is_ipv4(is_ipv4),
		.checksum_valid(checksum_valid),
		.checksum(checksum)
	);

	bind header_capture_top header_capture_properties header_capture_properties_inst (.*);

	initial clock = 1'b0;
	always #(CLOCK_PERIOD / 2) clock = ~clock;

	task automatic report_value(input string message);
		error_count++;
		$display("[FAIL] %0t: %s", $time, message);
	endtask

	task automatic report_problem(input string message);
		error_count++;
		$display("Error at time %0t: %s", $time, message);
	endtask

	function automatic mac_address_t random_mac();
		logic [31:0] high;
		logic [31:0] low;
		high = lfsr_draw(payload_lfsr, 24);
		low = lfsr_draw(payload_lfsr, 24);
		return {high[23:0], low[23:0]};
	endfunction

	// Queues the expected beats, fields and checksum, then sends the frame
	task automatic run_frame(input mac_address_t destination, input mac_address_t source,
			input ether_type_t frame_type, input int payload_length);
		byte unsigned frame_bytes[$];
		byte unsigned payload[$];
		byte unsigned value;
		frame_bytes = {};
		payload = {};
		for (int k = 5; k >= 0; k--) begin
			frame_bytes.push_back(destination[8*k +: 8]);
		end
		for (int k = 5; k >= 0; k--) begin
			frame_bytes.push_back(source[8*k +: 8]);
		end
		frame_bytes.push_back(frame_type[15:8]);
		frame_bytes.push_back(frame_type[7:0]);
		for (int k = 0; k < payload_length; k++) begin
			value = 8'(lfsr_draw(payload_lfsr, 8));
			payload.push_back(value);
			frame_bytes.push_back(value);
		end
		for (int k = 0; k < payload_length; k += 2) begin
			if (k + 1 < payload_length) begin
				expected_beats.push_back({k + 2 >= payload_length, 2'b11,
					payload[k+1], payload[k]});
			end else begin
				expected_beats.push_back({1'b1, 2'b01, 8'h00, payload[k]});
			end
		end
		expected_headers.push_back({destination, source, frame_type, frame_type == 16'h0800});
		expected_checksums.push_back(reference_checksum(payload));
		send_frame(frame_bytes);
	endtask

	task automatic check_beat();
		logic [18:0] expected;
		logic [112:0] header;
		if (expected_beats.size() == 0) begin
			report_problem("An output beat appeared when none was expected");
			return;
		end
		expected = expected_beats.pop_front();
		check_count++;
		assert ({out_last, out_keep, out_data} == expected) else
			report_value($sformatf("output beat %h, expected %h",
				{out_last, out_keep, out_data}, expected));
		if (out_last) begin
			frame_count++;
			if (expected_headers.size() == 0) begin
				report_problem("A frame ended with no header expected");
			end else begin
				header = expected_headers.pop_front();
				check_count++;
				assert (header_valid
						&& {destination_mac, source_mac, ether_type, is_ipv4} == header)
					else report_value($sformatf("header %b %h, expected %h", header_valid,
						{destination_mac, source_mac, ether_type, is_ipv4}, header));
			end
		end
	endtask

	task automatic check_checksum();
		checksum_t expected;
		if (expected_checksums.size() == 0) begin
			report_problem("A checksum was reported with none expected");
			return;
		end
		expected = expected_checksums.pop_front();
		check_count++;
		assert (checksum == expected) else
			report_value($sformatf("checksum %h, expected %h", checksum, expected));
	endtask

	task automatic finish_test(input string name);
		while (expected_beats.size() != 0 || expected_checksums.size() != 0 || header_valid) begin
			@(posedge clock);
		end
		$display("Test %s finished with %0d errors", name, error_count - errors_before);
		errors_before = error_count;
	endtask

	// Sink stalls on about one cycle in four
	always @(posedge clock) begin
		if (stall_enable) begin
			out_ready <= (lfsr_draw(ready_lfsr, 2) != 0);
		end else begin
			out_ready <= 1'b1;
		end
	end

	always @(posedge clock) begin
		if (reset) begin
			checksum_due <= 1'b0;
			held_valid <= 1'b0;
		end else begin
			check_count++;
			assert (checksum_valid == checksum_due)
				else report_problem(
					"checksum_valid did not pulse exactly one cycle after a last beat");
			checksum_due <= out_valid && out_ready && out_last;
			held_valid <= out_valid && !out_ready;
			held_beat <= {out_last, out_keep, out_data};
			if (held_valid) begin
				check_count++;
				assert (out_valid && {out_last, out_keep, out_data} == held_beat)
					else report_problem("The output beat changed or vanished while stalled");
			end
			if (header_forbidden) begin
				check_count++;
				assert (!header_valid)
					else report_problem("header_valid rose for a frame that ended in its header");
			end
			if (checksum_valid) begin
				check_checksum();
			end
			if (out_valid && out_ready) begin
				check_beat();
			end
		end
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		byte unsigned truncated[$];
		reset = 1'b1;
		in_valid = 1'b0;
		in_data = '0;
		in_keep = '0;
		in_last = 1'b0;
		out_ready = 1'b0;
		payload_lfsr = LFSR_SEED;
		ready_lfsr = LFSR_SEED;
		stall_enable = 1'b0;
		header_forbidden = 1'b0;
		check_count = 0;
		error_count = 0;
		errors_before = 0;
		frame_count = 0;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		check_count++;
		assert (!out_valid && !header_valid && !checksum_valid && in_ready)
			else report_problem("Outputs were not in their reset state after reset");

		run_frame(random_mac(), random_mac(), 16'h0800, IPV4_LENGTH);
		finish_test("ipv4 frame");
		run_frame(random_mac(), random_mac(), 16'h86DD, OTHER_LENGTH);
		finish_test("non-ipv4 ethertype");
		run_frame(random_mac(), random_mac(), 16'h0800, ODD_LENGTH);
		finish_test("odd payload length");

		stall_enable <= 1'b1;
		run_frame(random_mac(), random_mac(), 16'h0800, STALL_LENGTH_0);
		run_frame(random_mac(), random_mac(), 16'h0806, STALL_LENGTH_1);
		run_frame(random_mac(), random_mac(), 16'h0800, STALL_LENGTH_2);
		run_frame(random_mac(), random_mac(), 16'h88CC, STALL_LENGTH_3);
		finish_test("back-to-back frames with stalls");
		stall_enable <= 1'b0;

		// Frame cut short in its header, then a normal one
		header_forbidden <= 1'b1;
		for (int k = 0; k < TRUNCATED_BYTES; k++) begin
			truncated.push_back(8'(lfsr_draw(payload_lfsr, 8)));
		end
		send_frame(truncated);
		repeat (HEADER_BEATS) @(posedge clock);
		header_forbidden <= 1'b0;
		run_frame(random_mac(), random_mac(), 16'h0800, RECOVERY_LENGTH);
		finish_test("frame ending in its header");

		$display("Checks: %0d, errors: %0d, frames: %0d", check_count, error_count, frame_count);
		if (error_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+include
source/header_capture_pkg.sv
source/stream_header_splitter.sv
source/ethernet_header_decoder.sv
source/payload_checksum.sv
source/header_capture_top.sv
verification/header_capture_properties.sv
verification/header_capture_tb.sv
